//--- mp3_panel_defs.svh
`ifndef MP3_PANEL_DEFS_SVH
`define MP3_PANEL_DEFS_SVH

////////////////////////////////////////
// screen geometry
////////////////////////////////////////

`define PANEL_H_RES        640
`define PANEL_V_RES        480

// one drawing unit is a 64th of the screen height
`define PANEL_SQ           (`PANEL_V_RES / 64)

// anchor with the board held level
`define PANEL_SX_DEF       (`PANEL_H_RES / 2)
`define PANEL_SY_DEF       ((`PANEL_V_RES / 2) + (`PANEL_V_RES / 4))

////////////////////////////////////////
// widths
////////////////////////////////////////

`define PANEL_COORD_W      16
`define PANEL_TILT_W       8
`define PANEL_COLOR_W      4
`define PANEL_VOL_LVL_W    4

////////////////////////////////////////
// layout and timing
////////////////////////////////////////

// horizontal distances from the play icon
`define PANEL_TRACK_OFS    (16 * `PANEL_SQ)
`define PANEL_VOL_OFS      (36 * `PANEL_SQ)

// extra pixels around a highlight frame
`define PANEL_FRAME_MARGIN 3
`define PANEL_VOL_SEGS     8

// highlight hold after a track button press, in cycles
`define PANEL_HOLD_CYCLES  50

`endif

//--- mp3_panel_pkg.sv
`include "mp3_panel_defs.svh"

package mp3_panel_pkg;

    // signed screen coordinate
    // shapes near the left or top edge can go negative
    typedef logic signed [`PANEL_COORD_W-1:0] coord_t;

    typedef struct packed {
        logic [`PANEL_COLOR_W-1:0] red;
        logic [`PANEL_COLOR_W-1:0] green;
        logic [`PANEL_COLOR_W-1:0] blue;
    } rgb_t;

    // track button highlight FSM
    typedef enum logic {
        HOLD_IDLE,
        HOLD_ACTIVE
    } hold_state_t;

    // what a pixel shows, highest priority first
    typedef enum logic [1:0] {
        PAINT_ICON,
        PAINT_FRAME,
        PAINT_VOL,
        PAINT_NONE
    } paint_t;

endpackage

//--- pixel_hits_if.sv
interface pixel_hits_if;

    // registered shape hits for one pixel
    logic icon_hit;
    logic next_frame_hit;
    logic pre_frame_hit;
    logic vol_hit;

    modport shapes (
        output icon_hit,
        output next_frame_hit,
        output pre_frame_hit,
        output vol_hit
    );

    modport mixer (
        input icon_hit,
        input next_frame_hit,
        input pre_frame_hit,
        input vol_hit
    );

endinterface

//--- panel_anchor.sv
`include "mp3_panel_defs.svh"

module panel_anchor (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic signed [`PANEL_TILT_W-1:0] i_tilt_x,
    input  logic signed [`PANEL_TILT_W-1:0] i_tilt_y,
    output mp3_panel_pkg::coord_t           o_sx,
    output mp3_panel_pkg::coord_t           o_sy
);

    localparam mp3_panel_pkg::coord_t SX_DEF = mp3_panel_pkg::coord_t'(`PANEL_SX_DEF);
    localparam mp3_panel_pkg::coord_t SY_DEF = mp3_panel_pkg::coord_t'(`PANEL_SY_DEF);

    mp3_panel_pkg::coord_t tgt_x;
    mp3_panel_pkg::coord_t tgt_y;
    mp3_panel_pkg::coord_t sx_q;
    mp3_panel_pkg::coord_t sy_q;

    // one pixel toward the target, or stay
    function automatic mp3_panel_pkg::coord_t step_toward(
        input mp3_panel_pkg::coord_t cur,
        input mp3_panel_pkg::coord_t tgt
    );
        if (cur < tgt) begin
            return cur + mp3_panel_pkg::coord_t'(1);
        end else if (cur > tgt) begin
            return cur - mp3_panel_pkg::coord_t'(1);
        end
        return cur;
    endfunction

    ////////////////////////////////////////
    // tilt to target
    ////////////////////////////////////////

    // tilt y slides the panel sideways, tilt x up and down
    assign tgt_x = SX_DEF - mp3_panel_pkg::coord_t'(i_tilt_y);
    assign tgt_y = SY_DEF + mp3_panel_pkg::coord_t'(i_tilt_x);

    ////////////////////////////////////////
    // tracker
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sx_q <= SX_DEF;
            sy_q <= SY_DEF;
        end else begin
            sx_q <= step_toward(sx_q, tgt_x);
            sy_q <= step_toward(sy_q, tgt_y);
        end
    end

    assign o_sx = sx_q;
    assign o_sy = sy_q;

endmodule

//--- button_hold.sv
`include "mp3_panel_defs.svh"

module button_hold (
    input  logic clk,
    input  logic rst_n,
    input  logic i_press,
    output logic o_highlight
);

    localparam int CNT_W = $clog2(`PANEL_HOLD_CYCLES + 1);
    localparam logic [CNT_W-1:0] HOLD_LAST = CNT_W'(`PANEL_HOLD_CYCLES);

    mp3_panel_pkg::hold_state_t state_q;
    mp3_panel_pkg::hold_state_t state_d;
    logic [CNT_W-1:0]           cnt_q;
    logic [CNT_W-1:0]           cnt_d;

    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        case (state_q)
            mp3_panel_pkg::HOLD_IDLE: begin
                if (i_press) begin
                    state_d = mp3_panel_pkg::HOLD_ACTIVE;
                    cnt_d   = '0;
                end
            end
            mp3_panel_pkg::HOLD_ACTIVE: begin
                // presses are ignored until the hold expires
                if (cnt_q == HOLD_LAST) begin
                    state_d = mp3_panel_pkg::HOLD_IDLE;
                    cnt_d   = '0;
                end else begin
                    cnt_d = cnt_q + 1'b1;
                end
            end
            default: begin
                state_d = mp3_panel_pkg::HOLD_IDLE;
                cnt_d   = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= mp3_panel_pkg::HOLD_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

    // high for HOLD_CYCLES+1 cycles per accepted press
    assign o_highlight = (state_q == mp3_panel_pkg::HOLD_ACTIVE);

endmodule

//--- panel_shapes.sv
`include "mp3_panel_defs.svh"

module panel_shapes (
    input  logic                        clk,
    input  logic                        rst_n,
    input  mp3_panel_pkg::coord_t       i_x,
    input  mp3_panel_pkg::coord_t       i_y,
    input  mp3_panel_pkg::coord_t       i_sx,
    input  mp3_panel_pkg::coord_t       i_sy,
    input  logic                        i_pause,
    input  logic                        i_next_hl,
    input  logic                        i_pre_hl,
    input  logic                        i_vol_plus,
    input  logic                        i_vol_dec,
    input  logic [`PANEL_VOL_LVL_W-1:0] i_vol_level,
    pixel_hits_if.shapes                o_hits
);

    localparam mp3_panel_pkg::coord_t SQ  = mp3_panel_pkg::coord_t'(`PANEL_SQ);
    localparam mp3_panel_pkg::coord_t SQ2 = mp3_panel_pkg::coord_t'(2 * `PANEL_SQ);
    localparam mp3_panel_pkg::coord_t SQ3 = mp3_panel_pkg::coord_t'(3 * `PANEL_SQ);
    localparam mp3_panel_pkg::coord_t SQ4 = mp3_panel_pkg::coord_t'(4 * `PANEL_SQ);
    localparam mp3_panel_pkg::coord_t TRK = mp3_panel_pkg::coord_t'(`PANEL_TRACK_OFS);
    localparam mp3_panel_pkg::coord_t VOL = mp3_panel_pkg::coord_t'(`PANEL_VOL_OFS);
    localparam mp3_panel_pkg::coord_t MRG = mp3_panel_pkg::coord_t'(`PANEL_FRAME_MARGIN);

    mp3_panel_pkg::coord_t      nx;
    mp3_panel_pkg::coord_t      px;
    mp3_panel_pkg::coord_t      vx;
    mp3_panel_pkg::coord_t      vb;
    mp3_panel_pkg::coord_t      d;
    logic                       icon_rows;
    logic                       play_hit;
    logic                       pause_hit;
    logic                       next_hit;
    logic                       pre_hit;
    logic                       frame_rows;
    logic                       vol_col;
    logic [`PANEL_VOL_SEGS-1:0] seg_rows;
    logic [`PANEL_VOL_SEGS-1:0] lit_mask;

    // anchors of the side icons and the volume bar
    assign nx = i_sx + TRK;
    assign px = i_sx - TRK;
    assign vx = i_sx + VOL;
    assign vb = i_sy - SQ;

    ////////////////////////////////////////
    // icons
    ////////////////////////////////////////

    assign icon_rows = (i_y >= i_sy) && (i_y < i_sy + SQ4);

    // triangle half width, grows to the middle row then shrinks
    assign d = (i_y <= i_sy + SQ2) ? (i_y - i_sy) : (i_sy + SQ4 - i_y);

    assign play_hit  = (i_x >= i_sx) && (i_x < i_sx + d);
    assign pause_hit = ((i_x >= i_sx) && (i_x < i_sx + SQ)) ||
                       ((i_x >= i_sx + SQ2) && (i_x < i_sx + SQ3));

    // triangle plus a bar on the side it points away from
    assign next_hit = ((i_x >= nx) && (i_x < nx + d)) ||
                      ((i_x >= nx - SQ2) && (i_x < nx - SQ));
    assign pre_hit  = ((i_x >= px + SQ2 - d) && (i_x < px + SQ2)) ||
                      ((i_x >= px + SQ3) && (i_x < px + SQ4));

    assign frame_rows = (i_y >= i_sy - MRG) && (i_y < i_sy + SQ4 + MRG);

    ////////////////////////////////////////
    // volume bar
    ////////////////////////////////////////

    assign vol_col = (i_x >= vx) && (i_x < vx + SQ2);

    // segment 0 sits at the bottom, one unit gap between segments
    for (genvar k = 0; k < `PANEL_VOL_SEGS; k++) begin : g_seg
        assign seg_rows[k] =
            (i_y >= vb - mp3_panel_pkg::coord_t'((2 * k + 1) * `PANEL_SQ)) &&
            (i_y <  vb - mp3_panel_pkg::coord_t'(2 * k * `PANEL_SQ));
    end

    // 8 - level segments lit, none once the level passes 8
    assign lit_mask = {`PANEL_VOL_SEGS{1'b1}} >> i_vol_level;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_hits.icon_hit       <= 1'b0;
            o_hits.next_frame_hit <= 1'b0;
            o_hits.pre_frame_hit  <= 1'b0;
            o_hits.vol_hit        <= 1'b0;
        end else begin
            o_hits.icon_hit       <= icon_rows &&
                                     ((i_pause ? play_hit : pause_hit) || next_hit || pre_hit);
            o_hits.next_frame_hit <= i_next_hl && frame_rows &&
                                     (i_x >= nx - SQ2 - MRG) && (i_x < nx + SQ2 + MRG);
            o_hits.pre_frame_hit  <= i_pre_hl && frame_rows &&
                                     (i_x >= px - MRG) && (i_x < px + SQ4 + MRG);
            o_hits.vol_hit        <= (i_vol_plus || i_vol_dec) && vol_col &&
                                     (|(seg_rows & lit_mask));
        end
    end

endmodule

//--- pixel_mixer.sv
`include "mp3_panel_defs.svh"

module pixel_mixer (
    input  logic                      clk,
    input  logic                      rst_n,
    pixel_hits_if.mixer               i_hits,
    output logic [`PANEL_COLOR_W-1:0] o_red,
    output logic [`PANEL_COLOR_W-1:0] o_green,
    output logic [`PANEL_COLOR_W-1:0] o_blue
);

    localparam mp3_panel_pkg::rgb_t WHITE  = '{red: '1, green: '1, blue: '1};
    localparam mp3_panel_pkg::rgb_t YELLOW = '{red: '1, green: '1, blue: '0};
    localparam mp3_panel_pkg::rgb_t BLACK  = '{red: '0, green: '0, blue: '0};

    mp3_panel_pkg::paint_t paint;
    mp3_panel_pkg::rgb_t   rgb_d;
    mp3_panel_pkg::rgb_t   rgb_q;

    // icons sit on top of the frames
    always_comb begin
        if (i_hits.icon_hit) begin
            paint = mp3_panel_pkg::PAINT_ICON;
        end else if (i_hits.next_frame_hit || i_hits.pre_frame_hit) begin
            paint = mp3_panel_pkg::PAINT_FRAME;
        end else if (i_hits.vol_hit) begin
            paint = mp3_panel_pkg::PAINT_VOL;
        end else begin
            paint = mp3_panel_pkg::PAINT_NONE;
        end
    end

    always_comb begin
        case (paint)
            mp3_panel_pkg::PAINT_ICON:  rgb_d = WHITE;
            mp3_panel_pkg::PAINT_FRAME: rgb_d = YELLOW;
            mp3_panel_pkg::PAINT_VOL:   rgb_d = WHITE;
            default:                    rgb_d = BLACK;
        endcase
    end

    ////////////////////////////////////////
    // output register
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rgb_q <= BLACK;
        end else begin
            rgb_q <= rgb_d;
        end
    end

    assign o_red   = rgb_q.red;
    assign o_green = rgb_q.green;
    assign o_blue  = rgb_q.blue;

endmodule

//--- mp3_panel_overlay.sv
`include "mp3_panel_defs.svh"

module mp3_panel_overlay (
    input  logic                            clk,
    input  logic                            rst_n,
    input  mp3_panel_pkg::coord_t           i_x,
    input  mp3_panel_pkg::coord_t           i_y,
    input  logic signed [`PANEL_TILT_W-1:0] i_tilt_x,
    input  logic signed [`PANEL_TILT_W-1:0] i_tilt_y,
    input  logic                            i_next,
    input  logic                            i_pre,
    input  logic                            i_pause,
    input  logic                            i_vol_plus,
    input  logic                            i_vol_dec,
    input  logic [`PANEL_VOL_LVL_W-1:0]     i_vol_level,
    output logic [`PANEL_COLOR_W-1:0]       o_red,
    output logic [`PANEL_COLOR_W-1:0]       o_green,
    output logic [`PANEL_COLOR_W-1:0]       o_blue
);

    // panel anchor and track highlights
    mp3_panel_pkg::coord_t sx;
    mp3_panel_pkg::coord_t sy;
    logic                  next_hl;
    logic                  pre_hl;

    // stage 1 to stage 2
    pixel_hits_if u_hits ();

    panel_anchor u_anchor (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_tilt_x (i_tilt_x),
        .i_tilt_y (i_tilt_y),
        .o_sx     (sx),
        .o_sy     (sy)
    );

    button_hold u_next_hold (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_press     (i_next),
        .o_highlight (next_hl)
    );

    button_hold u_pre_hold (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_press     (i_pre),
        .o_highlight (pre_hl)
    );

    panel_shapes u_shapes (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_x         (i_x),
        .i_y         (i_y),
        .i_sx        (sx),
        .i_sy        (sy),
        .i_pause     (i_pause),
        .i_next_hl   (next_hl),
        .i_pre_hl    (pre_hl),
        .i_vol_plus  (i_vol_plus),
        .i_vol_dec   (i_vol_dec),
        .i_vol_level (i_vol_level),
        .o_hits      (u_hits.shapes)
    );

    pixel_mixer u_mixer (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_hits  (u_hits.mixer),
        .o_red   (o_red),
        .o_green (o_green),
        .o_blue  (o_blue)
    );

endmodule

//--- mp3_panel_asserts.sv
`include "mp3_panel_defs.svh"

module mp3_panel_asserts (
    input logic                      clk,
    input logic                      rst_n,
    input mp3_panel_pkg::coord_t     i_sx,
    input mp3_panel_pkg::coord_t     i_sy,
    input logic [`PANEL_COLOR_W-1:0] i_red,
    input logic [`PANEL_COLOR_W-1:0] i_green,
    input logic [`PANEL_COLOR_W-1:0] i_blue
);

    localparam mp3_panel_pkg::coord_t STEP = mp3_panel_pkg::coord_t'(1);

    // black while reset is held
    reset_black: assert property (@(posedge clk)
        !rst_n |-> (i_red == '0) && (i_green == '0) && (i_blue == '0))
        else $error("colour outputs not zero during reset");

    // anchor moves at most one pixel per axis per cycle
    anchor_step_x: assert property (@(posedge clk) disable iff (!rst_n)
        (i_sx == $past(i_sx)) || (i_sx == $past(i_sx) + STEP) || (i_sx == $past(i_sx) - STEP))
        else $error("anchor x moved more than one pixel in a cycle");

    anchor_step_y: assert property (@(posedge clk) disable iff (!rst_n)
        (i_sy == $past(i_sy)) || (i_sy == $past(i_sy) + STEP) || (i_sy == $past(i_sy) - STEP))
        else $error("anchor y moved more than one pixel in a cycle");

endmodule

bind mp3_panel_overlay mp3_panel_asserts u_asserts (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_sx    (sx),
    .i_sy    (sy),
    .i_red   (o_red),
    .i_green (o_green),
    .i_blue  (o_blue)
);

//--- tb_mp3_panel_overlay.sv
`include "mp3_panel_defs.svh"

module tb_mp3_panel_overlay;

    localparam int SQ      = `PANEL_SQ;
    localparam int MRG     = `PANEL_FRAME_MARGIN;
    localparam int SX_DEF  = `PANEL_SX_DEF;
    localparam int SY_DEF  = `PANEL_SY_DEF;
    localparam int NEXT_FX = SX_DEF + `PANEL_TRACK_OFS - 2 * SQ - MRG - 2;
    localparam int PRE_FX  = SX_DEF - `PANEL_TRACK_OFS - MRG - 2;
    localparam int FRAME_Y = SY_DEF - MRG - 2;
    localparam int FRAME_W = 4 * SQ + 2 * MRG + 4;
    localparam int VOL_X   = SX_DEF + `PANEL_VOL_OFS - 6;
    localparam int VOL_Y   = SY_DEF - SQ - 16 * SQ - 4;
    localparam int VOL_LEVELS [4] = '{0, 3, 8, 12};
    // reset, then the stimulus cycles of each test with three flush cycles each
    localparam int RUN_CYCLES     = 16 + 502 + 97 + 124 + 465 + 431 + 5 * 3;
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + 200;

    logic                            clk = 1'b0;
    logic                            rst_n;
    mp3_panel_pkg::coord_t           i_x;
    mp3_panel_pkg::coord_t           i_y;
    logic signed [`PANEL_TILT_W-1:0] i_tilt_x;
    logic signed [`PANEL_TILT_W-1:0] i_tilt_y;
    logic                            i_next;
    logic                            i_pre;
    logic                            i_pause;
    logic                            i_vol_plus;
    logic                            i_vol_dec;
    logic [`PANEL_VOL_LVL_W-1:0]     i_vol_level;
    logic [`PANEL_COLOR_W-1:0]       o_red;
    logic [`PANEL_COLOR_W-1:0]       o_green;
    logic [`PANEL_COLOR_W-1:0]       o_blue;

    logic [31:0] lfsr_state = 32'hc4e765c0;
    string       test_name = "reset";
    int          cycle_cnt = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    int          n_lit = 0;
    int          lit_errors = 0;
    int          checks_start;
    int          errors_start;
    int          lit_start;

    // reference model state
    int          m_sx;
    int          m_sy;
    int          next_rem;
    int          pre_rem;
    logic [11:0] exp_q0;
    logic [11:0] exp_q1;
    logic [1:0]  vld;

    mp3_panel_overlay u_mp3_panel_overlay (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_x         (i_x),
        .i_y         (i_y),
        .i_tilt_x    (i_tilt_x),
        .i_tilt_y    (i_tilt_y),
        .i_next      (i_next),
        .i_pre       (i_pre),
        .i_pause     (i_pause),
        .i_vol_plus  (i_vol_plus),
        .i_vol_dec   (i_vol_dec),
        .i_vol_level (i_vol_level),
        .o_red       (o_red),
        .o_green     (o_green),
        .o_blue      (o_blue)
    );

    always #4 clk = ~clk;

    ////////////////////////////////////////
    // random numbers
    ////////////////////////////////////////

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            r = (r << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_step(lfsr_state);
        end
        return r;
    endfunction

    ////////////////////////////////////////
    // reference
    ////////////////////////////////////////

    function automatic logic [11:0] expected_rgb(
        input int   x,
        input int   y,
        input int   sx,
        input int   sy,
        input logic pause,
        input logic next_hl,
        input logic pre_hl,
        input logic vol_on,
        input int   level
    );
        int   d;
        int   nx;
        int   px;
        int   vb;
        int   lit;
        logic icon;
        logic frame;
        logic vol;
        nx = sx + `PANEL_TRACK_OFS;
        px = sx - `PANEL_TRACK_OFS;
        vb = sy - SQ;
        d = (y <= sy + 2 * SQ) ? y - sy : sy + 4 * SQ - y;
        if (pause) begin
            icon = (x >= sx) && (x < sx + d);
        end else begin
            icon = (x >= sx && x < sx + SQ) || (x >= sx + 2 * SQ && x < sx + 3 * SQ);
        end
        icon = icon || (x >= nx && x < nx + d) || (x >= nx - 2 * SQ && x < nx - SQ);
        icon = icon || (x >= px + 2 * SQ - d && x < px + 2 * SQ);
        icon = icon || (x >= px + 3 * SQ && x < px + 4 * SQ);
        icon = icon && (y >= sy) && (y < sy + 4 * SQ);
        frame = (next_hl && x >= nx - 2 * SQ - MRG && x < nx + 2 * SQ + MRG) ||
                (pre_hl && x >= px - MRG && x < px + 4 * SQ + MRG);
        frame = frame && (y >= sy - MRG) && (y < sy + 4 * SQ + MRG);
        // segments count up from the bottom of the bar
        lit = (level <= 8) ? 8 - level : 0;
        vol = 1'b0;
        for (int k = 1; k <= lit; k++) begin
            if (y >= vb - (2 * k - 1) * SQ && y < vb - (2 * k - 2) * SQ) begin
                vol = 1'b1;
            end
        end
        vol = vol && vol_on && (x >= sx + `PANEL_VOL_OFS) && (x < sx + `PANEL_VOL_OFS + 2 * SQ);
        return icon ? 12'hfff : (frame ? 12'hff0 : (vol ? 12'hfff : 12'h000));
    endfunction

    // anchor, highlights and the two-stage expected colour pipe
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_sx     <= SX_DEF;
            m_sy     <= SY_DEF;
            next_rem <= 0;
            pre_rem  <= 0;
            exp_q0   <= 12'h000;
            exp_q1   <= 12'h000;
            vld      <= 2'b00;
        end else begin
            exp_q0 <= expected_rgb(int'(i_x), int'(i_y), m_sx, m_sy, i_pause, next_rem > 0,
                                   pre_rem > 0, i_vol_plus || i_vol_dec, int'(i_vol_level));
            exp_q1 <= exp_q0;
            vld    <= {vld[0], 1'b1};
            m_sx   <= m_sx + ((SX_DEF - int'(i_tilt_y) > m_sx) ? 1 :
                              ((SX_DEF - int'(i_tilt_y) < m_sx) ? -1 : 0));
            m_sy   <= m_sy + ((SY_DEF + int'(i_tilt_x) > m_sy) ? 1 :
                              ((SY_DEF + int'(i_tilt_x) < m_sy) ? -1 : 0));
            // accepted press lights the frame for HOLD+1 cycles
            next_rem <= (next_rem > 0) ? next_rem - 1 : (i_next ? `PANEL_HOLD_CYCLES + 1 : 0);
            pre_rem  <= (pre_rem > 0) ? pre_rem - 1 : (i_pre ? `PANEL_HOLD_CYCLES + 1 : 0);
        end
    end

    always @(negedge clk) begin
        if (rst_n && vld[1]) begin
            n_checks++;
            if ({o_red, o_green, o_blue} != 12'h000) begin
                n_lit++;
            end
            assert ({o_red, o_green, o_blue} == exp_q1) else begin
                $display("mismatch in %s: expected %h, actual %h",
                         test_name, exp_q1, {o_red, o_green, o_blue});
                n_errors++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    task automatic sweep_area(input int x0, input int y0, input int w, input int h, input int n);
        int x;
        int y;
        repeat (n) begin
            x = x0 + rand_bits(10) % w;
            y = y0 + rand_bits(10) % h;
            @(posedge clk);
            i_x <= mp3_panel_pkg::coord_t'(x);
            i_y <= mp3_panel_pkg::coord_t'(y);
        end
    endtask

    task automatic start_test(input string name);
        test_name    = name;
        checks_start = n_checks;
        errors_start = n_errors;
        lit_start    = n_lit;
    endtask

    task automatic finish_test();
        repeat (3) @(posedge clk);
        assert (n_lit > lit_start) else begin
            $display("test %s never showed a lit pixel", test_name);
            lit_errors++;
        end
        $display("test %s done: %0d checks, %0d errors", test_name,
                 n_checks - checks_start, n_errors - errors_start);
    endtask

    initial begin
        rst_n       = 1'b1;
        i_x         = '0;
        i_y         = '0;
        i_tilt_x    = '0;
        i_tilt_y    = '0;
        i_next      = 1'b0;
        i_pre       = 1'b0;
        i_pause     = 1'b0;
        i_vol_plus  = 1'b0;
        i_vol_dec   = 1'b0;
        i_vol_level = '0;
        #1 rst_n = 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        start_test("reset_idle");
        for (int p = 0; p < 2; p++) begin
            @(posedge clk);
            i_pause <= (p == 1);
            sweep_area(SX_DEF - 125, SY_DEF - 10, 270, 45, 250);
        end
        finish_test();

        // frame lit during the hold, black after expiry
        start_test("next_highlight");
        @(posedge clk);
        i_next <= 1'b1;
        @(posedge clk);
        i_next <= 1'b0;
        sweep_area(NEXT_FX, FRAME_Y, FRAME_W, FRAME_W, 95);
        finish_test();

        // second press inside the hold is ignored
        start_test("pre_highlight");
        @(posedge clk);
        i_pre <= 1'b1;
        @(posedge clk);
        i_pre <= 1'b0;
        sweep_area(PRE_FX, FRAME_Y, FRAME_W, FRAME_W, 20);
        @(posedge clk);
        i_pre <= 1'b1;
        @(posedge clk);
        i_pre <= 1'b0;
        sweep_area(PRE_FX, FRAME_Y, FRAME_W, FRAME_W, 100);
        finish_test();

        start_test("volume_bar");
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            i_vol_level <= 4'(VOL_LEVELS[i]);
            i_vol_dec   <= (i % 2 == 0);
            i_vol_plus  <= (i % 2 == 1);
            sweep_area(VOL_X, VOL_Y, 2 * SQ + 12, 16 * SQ + 8, 100);
        end
        // full level, so only the released buttons keep the bar dark
        @(posedge clk);
        i_vol_level <= '0;
        i_vol_dec   <= 1'b0;
        i_vol_plus  <= 1'b0;
        sweep_area(VOL_X, VOL_Y, 2 * SQ + 12, 16 * SQ + 8, 60);
        finish_test();

        start_test("tilt_tracking");
        @(posedge clk);
        i_tilt_x <= 8'(rand_bits(8));
        i_tilt_y <= 8'(rand_bits(8));
        sweep_area(0, 0, 640, 480, 130);
        sweep_area(m_sx - 125, m_sy - 4, 290, 37, 300);
        finish_test();

        $display("summary: %0d checks, %0d errors", n_checks, n_errors + lit_errors);
        if (n_errors + lit_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+.
mp3_panel_pkg.sv
pixel_hits_if.sv
panel_anchor.sv
button_hold.sv
panel_shapes.sv
pixel_mixer.sv
mp3_panel_overlay.sv
mp3_panel_asserts.sv
tb_mp3_panel_overlay.sv

//--- run_sim.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -f sources.f --top-module tb_mp3_panel_overlay \
    -o tb_sim > sim.log 2>&1 &&
    ./obj_dir/tb_sim >> sim.log 2>&1 ||
    echo "build or simulation exited with an error" >> sim.log
grep -q "NO ERRORS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
